// File: Makefile
# Verilator build and run of the audio path testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_audio_path
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: audio_checker.sv
`timescale 1ns/10ps
`include "audio_macros.svh"

module audio_checker (
  input  logic                   hwclk,
  input  logic                   arst_n,
  input  logic                   adc_serial_in, // ADC pin as the DUT sees it
  input  logic                   mute,
  input  logic [`NUM_STAGES-1:0] effect_en,
  input  logic                   i2sclk,
  input  logic                   word_select,
  input  logic                   dac_out,
  output int                     error_count,   // Mismatches so far
  output int                     word_count     // DAC words compared so far
);

  localparam int PTR_W = (`ECHO_DEPTH > 1) ? $clog2(`ECHO_DEPTH) : 1;
  localparam int S_MAX = (1 <<< (`AUDIO_W - 1)) - 1; // +127
  localparam int S_MIN = -(1 <<< (`AUDIO_W - 1));    // -128

  typedef logic signed [`AUDIO_W-1:0] sample_t;

  sample_t             hist [`NUM_STAGES][`ECHO_DEPTH]; // Model delay line per stage
  logic [PTR_W-1:0]    ptr;                             // Oldest entry, shared by all stages
  logic [`AUDIO_W-1:0] exp_q [$];                       // DAC words still to come
  logic [`AUDIO_W-1:0] in_word;                         // ADC bits gathered so far
  logic [`AUDIO_W-1:0] out_word;                        // DAC bits gathered so far
  logic [3:0]          slot;                            // Own copy of the slot bit index
  logic                clk_q;                           // i2sclk one hwclk earlier
  int                  half_cnt;                        // hwclk samples since last i2sclk edge
  int                  errors_q = 0;
  int                  words_q = 0;

  assign error_count = errors_q;
  assign word_count  = words_q;

  function automatic sample_t clip(input int v);
    if (v > S_MAX) return sample_t'(S_MAX); // Positive rail
    if (v < S_MIN) return sample_t'(S_MIN); // Negative rail
    return sample_t'(v);
  endfunction

  // One frame through the whole echo chain, then the mute at tx
  task automatic model_frame(input sample_t s, input logic m,
                             input logic [`NUM_STAGES-1:0] en,
                             output logic [`AUDIO_W-1:0] y);
    sample_t x;
    sample_t stage_in;
    int      echo;
    x = s;
    for (int k = 0; k < `NUM_STAGES; k++) begin
      stage_in = x;
      echo = int'(hist[k][ptr]) >>> 1; // Sample from ECHO_DEPTH frames back, halved
      if (en[k]) begin
        x = clip(int'(stage_in) + echo);
      end
      hist[k][ptr] = stage_in; // Recorded even when the stage is off
    end
    ptr = (ptr == PTR_W'(`ECHO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    y = m ? '0 : x;
  endtask

  always @(posedge hwclk) begin : watch
    int                  errs;
    logic [`AUDIO_W-1:0] expected;
    logic [`AUDIO_W-1:0] next_exp;
    errs = 0;
    if (!arst_n) begin
      if (i2sclk !== 1'b0) begin
        $display("error at %0d ns: i2sclk expected 0, actual %b", $time, i2sclk);
        errs++;
      end
      if (word_select !== 1'b0) begin
        $display("error at %0d ns: word_select expected 0, actual %b", $time, word_select);
        errs++;
      end
      if (dac_out !== 1'b0) begin
        $display("error at %0d ns: dac_out expected 0, actual %b", $time, dac_out);
        errs++;
      end
      for (int k = 0; k < `NUM_STAGES; k++) begin
        for (int d = 0; d < `ECHO_DEPTH; d++) begin
          hist[k][d] = '0; // Delay lines start silent
        end
      end
      ptr = '0;
      exp_q.delete();
      exp_q.push_back('0); // First frame after reset is silent
      in_word  = '0;
      out_word = '0;
      slot     = '0;
      clk_q    = 1'b0;
      half_cnt = 0;
    end else begin
      if (!clk_q && i2sclk) begin // Bit clock rose, mid-bit for both pins
        if (slot < 4'(`AUDIO_W)) begin
          in_word  = {in_word[`AUDIO_W-2:0], adc_serial_in};
          out_word = {out_word[`AUDIO_W-2:0], dac_out};
          if (slot == 4'(`AUDIO_W - 1)) begin
            if (exp_q.size() == 0) begin
              $display("a DAC word finished at %0d ns with no expected word left", $time);
              errs++;
            end else begin
              expected = exp_q.pop_front();
              words_q <= words_q + 1;
              if (out_word !== expected) begin
                $display("error at %0d ns: dac_out word expected %0d, actual %0d",
                         $time, $signed(expected), $signed(out_word));
                errs++;
              end
            end
            model_frame(in_word, mute, effect_en, next_exp); // Due in the next frame
            exp_q.push_back(next_exp);
          end
        end else if (dac_out !== 1'b0) begin
          $display("error at %0d ns: dac_out expected 0, actual %b", $time, dac_out);
          errs++;
        end
        if (word_select !== (slot >= 4'(`AUDIO_W))) begin
          $display("error at %0d ns: word_select expected %b, actual %b",
                   $time, slot >= 4'(`AUDIO_W), word_select);
          errs++;
        end
      end
      if (clk_q && !i2sclk) begin
        slot = slot + 4'd1; // Wraps at 16
      end
      if (i2sclk !== clk_q) begin // Bit clock edge, half period just ended
        if (half_cnt != `I2S_HALF_DIV) begin
          $display("error at %0d ns: i2sclk half period expected %0d, actual %0d",
                   $time, `I2S_HALF_DIV, half_cnt);
          errs++;
        end
        half_cnt = 1;
      end else begin
        half_cnt++;
      end
      clk_q = i2sclk;
    end
    errors_q <= errors_q + errs;
  end

endmodule

// File: audio_macros.svh
`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// Audio sample width in bits, signed two's complement
`define AUDIO_W 8

// Echo stages chained between receiver and transmitter
`define NUM_STAGES 3

// Delay of each echo stage, counted in frames
`define ECHO_DEPTH 4

// hwclk cycles per half period of the I2S bit clock
`define I2S_HALF_DIV 4

`endif

// File: audio_path_top.sv
`timescale 1ns/10ps
`include "audio_macros.svh"

module audio_path_top (
  input  logic                   hwclk,
  input  logic                   arst_n,
  input  logic                   adc_serial_in, // From ADC
  input  logic                   mute,          // Push-to-talk mute
  input  logic [`NUM_STAGES-1:0] effect_en,     // One enable per echo stage
  output logic                   i2sclk,        // Bit clock to ADC and DAC
  output logic                   word_select,
  output logic                   dac_out        // To DAC
);

  // Link k feeds stage k, the last link feeds the transmitter
  audio_pkg::frame_t      link_frame [`NUM_STAGES+1];
  logic [`NUM_STAGES:0]   link_req;
  logic [`NUM_STAGES:0]   link_ack;

  logic       bit_rise;
  logic       bit_fall;
  logic [3:0] bit_idx;

  i2s_clkgen #(.HALF_DIV(`I2S_HALF_DIV)) i_i2s_clkgen (
    .hwclk(hwclk), .arst_n(arst_n),                           // From top
    .i2sclk(i2sclk), .word_select(word_select),               // To pins
    .bit_rise(bit_rise), .bit_fall(bit_fall), .bit_idx(bit_idx) // To rx and tx
  );

  i2s_rx i_i2s_rx (
    .hwclk(hwclk), .arst_n(arst_n),
    .adc_serial_in(adc_serial_in), .mute(mute),             // From pins
    .bit_rise(bit_rise), .bit_idx(bit_idx),                 // From clkgen
    .dn_frame(link_frame[0]), .dn_req(link_req[0]), .dn_ack(link_ack[0]) // To stage 0
  );

  for (genvar k = 0; k < `NUM_STAGES; k++) begin : g_stage
    echo_stage #(.DEPTH(`ECHO_DEPTH)) i_echo_stage (
      .hwclk(hwclk), .arst_n(arst_n),
      .echo_en(effect_en[k]),
      .up_frame(link_frame[k]), .up_req(link_req[k]), .up_ack(link_ack[k]),
      .dn_frame(link_frame[k+1]), .dn_req(link_req[k+1]), .dn_ack(link_ack[k+1])
    );
  end

  i2s_tx i_i2s_tx (
    .hwclk(hwclk), .arst_n(arst_n),
    .bit_fall(bit_fall), .bit_idx(bit_idx),                 // From clkgen
    .up_frame(link_frame[`NUM_STAGES]),                     // From last stage
    .up_req(link_req[`NUM_STAGES]), .up_ack(link_ack[`NUM_STAGES]),
    .dac_out(dac_out)                                       // To pin
  );

endmodule

// File: audio_pkg.sv
`include "audio_macros.svh"

// Types shared by every block on the voice path
package audio_pkg;

  // One audio frame as it travels from link to link
  typedef struct packed {
    logic signed [`AUDIO_W-1:0] sample; // Signed ADC word, MSB first on the wire
    logic                       mute;   // Mute input seen at the slot's last bit
  } frame_t;

endpackage

// File: echo_stage.sv
`timescale 1ns/10ps
`include "audio_macros.svh"

module echo_stage #(
  parameter int DEPTH = `ECHO_DEPTH // Echo delay in frames
) (
  input  logic              hwclk,
  input  logic              arst_n,
  input  logic              echo_en,  // Add the delayed copy
  input  audio_pkg::frame_t up_frame,
  input  logic              up_req,
  output logic              up_ack,
  output audio_pkg::frame_t dn_frame,
  output logic              dn_req,
  input  logic              dn_ack
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  localparam logic signed [`AUDIO_W-1:0] SAT_MAX = {1'b0, {(`AUDIO_W-1){1'b1}}}; // +127
  localparam logic signed [`AUDIO_W-1:0] SAT_MIN = {1'b1, {(`AUDIO_W-1){1'b0}}}; // -128

  typedef enum logic [1:0] {
    IDLE,   // Waiting for upstream req
    UP_REL, // Acked, waiting for upstream req to drop
    DN_ACK, // Downstream req up, waiting for ack
    DN_REL  // Waiting for downstream ack to drop
  } state_t;

  state_t                     state_q;
  logic signed [`AUDIO_W-1:0] hist_q [DEPTH]; // Circular buffer of own inputs
  logic [PTR_W-1:0]           wr_ptr_q;       // Oldest entry, overwritten next
  logic signed [`AUDIO_W-1:0] echo;           // Delayed sample halved
  logic signed [`AUDIO_W:0]   sum;            // One guard bit
  logic signed [`AUDIO_W-1:0] mixed;          // Clipped mix
  logic                       take;           // Accept upstream frame

  assign take = (state_q == IDLE) && up_req;
  assign echo = hist_q[wr_ptr_q] >>> 1; // Sample from DEPTH frames back
  assign sum  = {up_frame.sample[`AUDIO_W-1], up_frame.sample} + {echo[`AUDIO_W-1], echo};

  always_comb begin
    mixed = sum[`AUDIO_W-1:0];
    if (sum[`AUDIO_W] != sum[`AUDIO_W-1]) begin
      mixed = sum[`AUDIO_W] ? SAT_MIN : SAT_MAX; // Overflow, clip to rail
    end
  end

  // Output frame, loaded once per accepted input
  always_ff @(posedge hwclk) begin
    if (take) begin
      dn_frame.sample <= echo_en ? mixed : up_frame.sample;
      dn_frame.mute   <= up_frame.mute; // Mute rides along untouched
    end
  end

  // Delay line records every frame, enabled or not
  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        hist_q[i] <= '0;
      end
      wr_ptr_q <= '0;
    end else if (take) begin
      hist_q[wr_ptr_q] <= up_frame.sample;
      wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
    end
  end

  // Upstream handshake first, then downstream
  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
      up_ack  <= 1'b0;
      dn_req  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: if (up_req) begin
          up_ack  <= 1'b1;
          state_q <= UP_REL;
        end
        UP_REL: if (!up_req) begin
          up_ack  <= 1'b0;
          dn_req  <= 1'b1; // Frame already stable
          state_q <= DN_ACK;
        end
        DN_ACK: if (dn_ack) begin
          dn_req  <= 1'b0;
          state_q <= DN_REL;
        end
        default: if (!dn_ack) begin
          state_q <= IDLE; // Link closed, next frame may come in
        end
      endcase
    end
  end

endmodule

// File: i2s_clkgen.sv
`timescale 1ns/10ps
`include "audio_macros.svh"

module i2s_clkgen #(
  parameter int HALF_DIV = `I2S_HALF_DIV // hwclk cycles per bit-clock half period
) (
  input  logic       hwclk,
  input  logic       arst_n,
  output logic       i2sclk,      // Bit clock to the codec
  output logic       word_select, // Low in the audio slot
  output logic       bit_rise,    // One cycle after i2sclk goes high
  output logic       bit_fall,    // One cycle after i2sclk goes low
  output logic [3:0] bit_idx      // Slot bit 0 to 15
);

  localparam int CNT_W = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;

  logic [CNT_W-1:0] div_q;    // Half-period counter
  logic             edge_due; // Bit clock toggles this cycle

  assign edge_due = (div_q == CNT_W'(HALF_DIV - 1));

  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      div_q    <= '0;
      i2sclk   <= 1'b0;
      bit_rise <= 1'b0;
      bit_fall <= 1'b0;
      bit_idx  <= '0;
    end else begin
      bit_rise <= edge_due && !i2sclk; // Low to high
      bit_fall <= edge_due && i2sclk;  // High to low
      if (edge_due) begin
        div_q  <= '0;
        i2sclk <= !i2sclk;
        if (i2sclk) begin
          bit_idx <= bit_idx + 4'd1; // Advance on falling edge, wraps at 16
        end
      end else begin
        div_q <= div_q + 1'b1;
      end
    end
  end

  // Upper half of the 16-bit frame is the unused slot
  assign word_select = bit_idx[3];

endmodule

// File: i2s_rx.sv
`timescale 1ns/10ps
`include "audio_macros.svh"

module i2s_rx (
  input  logic              hwclk,
  input  logic              arst_n,
  input  logic              adc_serial_in, // Serial ADC data, MSB first
  input  logic              mute,          // Sampled with the last slot bit
  input  logic              bit_rise,      // Rising bit-clock strobe
  input  logic [3:0]        bit_idx,       // Current slot bit
  output audio_pkg::frame_t dn_frame,      // Frame to first echo stage
  output logic              dn_req,
  input  logic              dn_ack
);

  localparam logic [3:0] SLOT_BITS = 4'(`AUDIO_W);
  localparam logic [3:0] LAST_BIT  = 4'(`AUDIO_W - 1);

  logic [`AUDIO_W-2:0] shift_q;   // Slot bits 0 to W-2
  logic                in_slot;   // Sampling edge inside the audio slot
  logic                slot_end;  // Sampling edge of the last slot bit
  logic                link_free; // Previous handshake fully closed
  logic                launch;    // New frame goes out this cycle

  assign in_slot   = bit_rise && (bit_idx < SLOT_BITS);
  assign slot_end  = in_slot && (bit_idx == LAST_BIT);
  assign link_free = !dn_req && !dn_ack;
  assign launch    = slot_end && link_free; // Word is dropped otherwise

  // MSB enters first and ends up on top
  always_ff @(posedge hwclk) begin
    if (in_slot) begin
      shift_q <= {shift_q[`AUDIO_W-3:0], adc_serial_in};
    end
  end

  // Frame stays put while req is high and until the next launch
  always_ff @(posedge hwclk) begin
    if (launch) begin
      dn_frame.sample <= {shift_q, adc_serial_in}; // Last bit straight from the pin
      dn_frame.mute   <= mute;
    end
  end

  // Sender side of the four-phase link
  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      dn_req <= 1'b0;
    end else if (launch) begin
      dn_req <= 1'b1; // Phase 1
    end else if (dn_req && dn_ack) begin
      dn_req <= 1'b0; // Phase 3
    end
  end

endmodule

// File: i2s_tx.sv
`timescale 1ns/10ps
`include "audio_macros.svh"

module i2s_tx (
  input  logic              hwclk,
  input  logic              arst_n,
  input  logic              bit_fall,  // Falling bit-clock strobe
  input  logic [3:0]        bit_idx,   // Already advanced when bit_fall is high
  input  audio_pkg::frame_t up_frame,  // Frame from last echo stage
  input  logic              up_req,
  output logic              up_ack,
  output logic              dac_out    // Serial DAC data, MSB first
);

  localparam logic [3:0] SLOT_BITS = 4'(`AUDIO_W);

  audio_pkg::frame_t   hold_q;      // Latest accepted frame
  logic [`AUDIO_W-1:0] word;        // Word for the coming slot
  logic [`AUDIO_W-1:0] shift_q;     // Remaining bits, next one on top
  logic                frame_start; // Slot bit 0 begins
  logic                in_slot;     // Falling edge inside the audio slot

  assign word        = hold_q.mute ? '0 : hold_q.sample; // Muted frames go out silent
  assign frame_start = bit_fall && (bit_idx == 4'd0);
  assign in_slot     = bit_fall && (bit_idx < SLOT_BITS);

  // Receiver side, ack as soon as latched so the chain never stalls
  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      hold_q <= '0; // Silence until first frame arrives
      up_ack <= 1'b0;
    end else if (up_req && !up_ack) begin
      hold_q <= up_frame;
      up_ack <= 1'b1; // Phase 2
    end else if (!up_req && up_ack) begin
      up_ack <= 1'b0; // Phase 4
    end
  end

  // Slot serializer
  always_ff @(posedge hwclk or negedge arst_n) begin
    if (!arst_n) begin
      shift_q <= '0;
      dac_out <= 1'b0;
    end else if (frame_start) begin
      dac_out <= word[`AUDIO_W-1]; // MSB right at frame start
      shift_q <= {word[`AUDIO_W-2:0], 1'b0};
    end else if (in_slot) begin
      dac_out <= shift_q[`AUDIO_W-1];
      shift_q <= {shift_q[`AUDIO_W-2:0], 1'b0};
    end else if (bit_fall) begin
      dac_out <= 1'b0; // Idle in the unused slot
    end
  end

endmodule

// File: tb_audio_path.sv
`timescale 1ns/10ps
`include "audio_macros.svh"

module tb_audio_path;

  localparam int MODE_BYPASS  = 0;
  localparam int MODE_SINGLE  = 1;
  localparam int MODE_FULL    = 2;
  localparam int MODE_MUTE    = 3;
  localparam int MODE_MIX     = 4;
  localparam int TOTAL_FRAMES = 2 + 12 + 12 + 16 + 12 + 40 + 2;
  localparam int WATCHDOG_NS  = TOTAL_FRAMES * 32 * `I2S_HALF_DIV * 20 * 11 / 10;

  logic                   hwclk;
  logic                   arst_n        = 1'b1;
  logic                   adc_serial_in = 1'b0;
  logic                   mute          = 1'b0;
  logic [`NUM_STAGES-1:0] effect_en     = '0;
  logic                   i2sclk;
  logic                   word_select;
  logic                   dac_out;

  integer              seed       = 32'hd451;
  int                  mode       = MODE_BYPASS;
  int                  test_start = 0;  // frame_cnt when the current test began
  int                  frame_cnt  = 0;  // Frame starts seen since reset
  logic [3:0]          slot       = '0; // Slot bit as tracked from i2sclk
  logic                clk_q      = 1'b0;
  logic [`AUDIO_W-1:0] cur_word   = '0; // Word being sent in this slot
  int                  chk_errors;
  int                  chk_words;
  int                  tests_run    = 0;
  int                  tests_failed = 0;

  initial begin
    hwclk = 1'b0;
    forever #10 hwclk = ~hwclk;
  end

  audio_path_top i_audio_path_top (
    .hwclk(hwclk), .arst_n(arst_n), .adc_serial_in(adc_serial_in), .mute(mute),
    .effect_en(effect_en), .i2sclk(i2sclk), .word_select(word_select), .dac_out(dac_out)
  );

  audio_checker i_audio_checker (
    .hwclk(hwclk), .arst_n(arst_n), .adc_serial_in(adc_serial_in), .mute(mute),
    .effect_en(effect_en), .i2sclk(i2sclk), .word_select(word_select), .dac_out(dac_out),
    .error_count(chk_errors), .word_count(chk_words)
  );

  // ADC bits follow each falling bit-clock edge
  always @(posedge hwclk) begin : drive
    logic [3:0]          next_slot;
    logic [2:0]          bit_sel;
    logic [31:0]         rnd;
    logic [`AUDIO_W-1:0] mag;
    logic [`AUDIO_W-1:0] word_next;
    rnd = $random(seed);
    if (!arst_n) begin
      clk_q         <= 1'b0;
      slot          <= '0;
      cur_word      <= rnd[`AUDIO_W-1:0]; // Last pick becomes the first word
      adc_serial_in <= rnd[`AUDIO_W-1];
    end else begin
      clk_q <= i2sclk;
      if (clk_q && !i2sclk) begin
        next_slot = slot + 4'd1;
        slot <= next_slot;
        if (next_slot == 4'd0) begin // Frame start, new word MSB first
          if (mode == MODE_FULL) begin
            mag       = 8'd96 + {3'b000, rnd[4:0]};
            word_next = rnd[5] ? ~mag : mag; // 96..127 or -97..-128
          end else begin
            word_next = rnd[`AUDIO_W-1:0];
          end
          cur_word      <= word_next;
          adc_serial_in <= word_next[`AUDIO_W-1];
          frame_cnt     <= frame_cnt + 1;
        end else if (next_slot < 4'(`AUDIO_W)) begin
          bit_sel = 3'(`AUDIO_W - 1) - next_slot[2:0];
          adc_serial_in <= cur_word[bit_sel];
        end else begin
          adc_serial_in <= rnd[0]; // Unused slot carries noise
        end
        if (next_slot == 4'd12) begin // Controls move only in the unused slot
          case (mode)
            MODE_SINGLE: begin
              effect_en <= `NUM_STAGES'(1);
              mute      <= 1'b0;
            end
            MODE_FULL: begin
              effect_en <= '1;
              mute      <= 1'b0;
            end
            MODE_MUTE: begin
              effect_en <= '1;
              mute      <= (frame_cnt - test_start) < 5; // Muted burst, then echoes
            end
            MODE_MIX: begin
              effect_en <= rnd[8 +: `NUM_STAGES];
              mute      <= (rnd[13:12] == 2'b00);
            end
            default: begin
              effect_en <= '0;
              mute      <= 1'b0;
            end
          endcase
        end
      end
    end
  end

  task automatic wait_frames(input int n);
    int target;
    target = frame_cnt + n;
    while (frame_cnt < target) @(posedge hwclk);
  endtask

  task automatic run_test(input string name, input int test_mode, input int n);
    int errs0;
    int words0;
    int errs;
    int words;
    errs0  = (tests_run == 0) ? 0 : chk_errors; // First test also owns the reset checks
    words0 = chk_words;
    mode       <= test_mode;
    test_start <= frame_cnt;
    wait_frames(n);
    errs  = chk_errors - errs0;
    words = chk_words - words0;
    tests_run++;
    if (errs > 0) tests_failed++;
    $display("test %-12s %0d words checked, %0d errors, %s",
             name, words, errs, (errs == 0) ? "ok" : "FAILED");
  endtask

  // Runs past this point mean the DUT stopped making frames
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, frames stopped coming", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  initial begin : test_flow
    logic ok;
    ok = 1'b1;
    #2 arst_n = 1'b0;
    repeat (5) @(posedge hwclk);
    arst_n <= 1'b1;
    run_test("reset_state", MODE_BYPASS, 2);
    run_test("bypass", MODE_BYPASS, 12);
    run_test("single_echo", MODE_SINGLE, 12);
    run_test("full_chain", MODE_FULL, 16);
    run_test("mute", MODE_MUTE, 12);
    run_test("random_mix", MODE_MIX, 40);
    run_test("drain", MODE_BYPASS, 2); // Last captured word still in flight
    $display("tests %0d, failed %0d, words checked %0d, errors %0d",
             tests_run, tests_failed, chk_words, chk_errors);
    if (chk_words < TOTAL_FRAMES - 2) begin
      $display("only %0d DAC words were checked, too few for the run", chk_words);
      ok = 1'b0;
    end
    if (ok && tests_failed == 0 && chk_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
audio_pkg.sv
i2s_clkgen.sv
i2s_rx.sv
echo_stage.sv
i2s_tx.sv
audio_path_top.sv
audio_checker.sv
tb_audio_path.sv
